/* common/vga_pkg.sv */
// ##########################################################
// Types shared by the display controller, its FIFO path and
// the testbench memory model. Import where the types are used
// ##########################################################

package vga_pkg;

	// Byte address on the memory read channel
	typedef logic [31:0] bus_addr_t;

	// One framebuffer word
	// Bytes are R, G, B, A from the most significant end
	typedef logic [31:0] bus_data_t;

	// Single DAC colour channel
	typedef logic [7:0] color_t;

	// Index of a pixel within one frame
	// 19 bits covers 640 x 480
	typedef logic [18:0] pixel_count_t;

	// Burst fetch sequencer
	typedef enum logic [1:0]
	{
		// Idle until the raster enters vertical blanking
		wait_frame_start,

		// FIFO too full to take another whole burst
		wait_fifo_room,

		// Address presented, waiting for the slave
		issue_addr,

		// Collecting the words of one burst
		burst_active
	} fetch_state_t;

	// Raster state passed from the timing generator to the controller
	// All flags active high
	typedef struct packed
	{
		// One clock in two, marks a pixel slot
		logic pixel_enable;

		// Current pixel lies inside the visible area
		logic in_visible_region;

		// Single clock pulse at the start of vertical blanking
		logic new_frame;

		// Line lies inside the vertical sync pulse
		logic in_vsync;
	} raster_status_t;

endpackage

/* verilog/sync_fifo.sv */
// ##########################################################
// Single clock FIFO with flush and an almost empty level.
// Head entry is visible on value_out without a pop
// ##########################################################

module sync_fifo
#(
	parameter int DATA_WIDTH = 32,
	parameter int NUM_ENTRIES = 8,
	parameter int ALMOST_EMPTY_THRESHOLD = 1
)
(
	input clk,
	input reset,
	input flush,
	input enqueue,
	input dequeue,
	input [DATA_WIDTH-1:0] value_in,
	output logic [DATA_WIDTH-1:0] value_out,
	output logic empty,
	output logic full,
	output logic almost_empty
);

	localparam int PTR_WIDTH = NUM_ENTRIES > 1 ? $clog2(NUM_ENTRIES) : 1;
	localparam int COUNT_WIDTH = $clog2(NUM_ENTRIES + 1);
	localparam logic [PTR_WIDTH-1:0] LAST_INDEX = PTR_WIDTH'(NUM_ENTRIES - 1);
	localparam logic [COUNT_WIDTH-1:0] FULL_COUNT = COUNT_WIDTH'(NUM_ENTRIES);
	localparam logic [COUNT_WIDTH-1:0] THRESHOLD_COUNT = COUNT_WIDTH'(ALMOST_EMPTY_THRESHOLD);

	logic [DATA_WIDTH-1:0] storage [NUM_ENTRIES];
	logic [PTR_WIDTH-1:0] read_ptr;
	logic [PTR_WIDTH-1:0] write_ptr;
	logic [COUNT_WIDTH-1:0] count;
	logic push;
	logic pop;

	// Wrap explicitly so any depth works, not only powers of two
	function automatic logic [PTR_WIDTH-1:0] next_index(input logic [PTR_WIDTH-1:0] index);
		if (index == LAST_INDEX)
			return '0;
		return index + 1'b1;
	endfunction

	// Requests that cannot be served are ignored
	assign push = enqueue && !full;
	assign pop = dequeue && !empty;

	always_ff @(posedge clk)
	begin
		if (push)
			storage[write_ptr] <= value_in;
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else if (flush)
		begin
			// Flush wins over a push in the same clock
			read_ptr <= '0;
			write_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				write_ptr <= next_index(write_ptr);

			if (pop)
				read_ptr <= next_index(read_ptr);

			// Simultaneous push and pop leave the count alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	assign empty = count == '0;
	assign full = count == FULL_COUNT;
	assign almost_empty = count <= THRESHOLD_COUNT;

	// Head reads as zero when nothing is stored
	assign value_out = empty ? '0 : storage[read_ptr];

endmodule

/* vga/vga_timing_generator.sv */
// ##########################################################
// Raster timing for the display controller. Counts pixels and
// lines and drives pixel enable, sync, blank and frame start
// ##########################################################

module vga_timing_generator
#(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33
)
(
	input clk,
	input reset,
	output vga_pkg::raster_status_t status,
	output logic vga_hs,
	output logic vga_vs
);

	// Full line and frame lengths, porches included
	localparam int H_TOTAL = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
	localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
	localparam int H_WIDTH = $clog2(H_TOTAL);
	localparam int V_WIDTH = $clog2(V_TOTAL);

	// Boundaries in counter width
	localparam logic [H_WIDTH-1:0] H_LAST = H_WIDTH'(H_TOTAL - 1);
	localparam logic [H_WIDTH-1:0] H_VISIBLE_END = H_WIDTH'(H_VISIBLE);
	localparam logic [H_WIDTH-1:0] H_SYNC_START = H_WIDTH'(H_VISIBLE + H_FRONT);
	localparam logic [H_WIDTH-1:0] H_SYNC_END = H_WIDTH'(H_VISIBLE + H_FRONT + H_SYNC);
	localparam logic [V_WIDTH-1:0] V_LAST = V_WIDTH'(V_TOTAL - 1);
	localparam logic [V_WIDTH-1:0] V_VISIBLE_END = V_WIDTH'(V_VISIBLE);
	localparam logic [V_WIDTH-1:0] V_SYNC_START = V_WIDTH'(V_VISIBLE + V_FRONT);
	localparam logic [V_WIDTH-1:0] V_SYNC_END = V_WIDTH'(V_VISIBLE + V_FRONT + V_SYNC);

	logic pixel_enable;
	logic [H_WIDTH-1:0] h_count;
	logic [V_WIDTH-1:0] v_count;
	logic end_of_line;
	logic visible_q;
	logic new_frame_q;
	logic hsync_active;
	logic vsync_active;

	assign end_of_line = h_count == H_LAST;

	// Pixel clock is half the system clock
	// First high cycle follows the first edge out of reset
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			pixel_enable <= 1'b0;
		else
			pixel_enable <= !pixel_enable;
	end

	// Position counters, starting at the top left visible pixel
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			h_count <= '0;
			v_count <= '0;
		end
		else if (pixel_enable)
		begin
			if (end_of_line)
			begin
				h_count <= '0;
				// Line counter steps once per line
				if (v_count == V_LAST)
					v_count <= '0;
				else
					v_count <= v_count + 1'b1;
			end
			else
				h_count <= h_count + 1'b1;
		end
	end

	// Decoded flags for the pixel the counters point at
	// Held for the whole pixel slot that follows
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			visible_q <= 1'b0;
			new_frame_q <= 1'b0;
			hsync_active <= 1'b0;
			vsync_active <= 1'b0;
		end
		else
		begin
			// Only one clock wide, so cleared on the next edge
			new_frame_q <= pixel_enable && h_count == '0 && v_count == V_VISIBLE_END;

			if (pixel_enable)
			begin
				visible_q <= h_count < H_VISIBLE_END && v_count < V_VISIBLE_END;
				hsync_active <= h_count >= H_SYNC_START && h_count < H_SYNC_END;
				vsync_active <= v_count >= V_SYNC_START && v_count < V_SYNC_END;
			end
		end
	end

	assign status = '{
		pixel_enable: pixel_enable,
		in_visible_region: visible_q,
		new_frame: new_frame_q,
		in_vsync: vsync_active
	};

	// DAC syncs are active low
	assign vga_hs = !hsync_active;
	assign vga_vs = !status.in_vsync;

endmodule

/* vga/vga_controller.sv */
// ##########################################################
// Display controller top. Fetches the RGBA framebuffer in read
// bursts and streams pixels with raster timing to a video DAC
// ##########################################################

module vga_controller
#(
	parameter int H_VISIBLE = 640,
	parameter int H_FRONT = 16,
	parameter int H_SYNC = 96,
	parameter int H_BACK = 48,
	parameter int V_VISIBLE = 480,
	parameter int V_FRONT = 10,
	parameter int V_SYNC = 2,
	parameter int V_BACK = 33,
	parameter int BURST_LENGTH = 64,
	parameter int FIFO_DEPTH = 128,
	parameter vga_pkg::bus_addr_t FB_BASE_ADDR = 32'h10000000
)
(
	input clk,
	input reset,

	// Video DAC
	output vga_pkg::color_t vga_r,
	output vga_pkg::color_t vga_g,
	output vga_pkg::color_t vga_b,
	output logic vga_clk,
	output logic vga_blank_n,
	output logic vga_hs,
	output logic vga_vs,

	// Memory read channel
	output vga_pkg::bus_addr_t axi_araddr,
	output logic axi_arvalid,
	input axi_arready,
	input axi_rvalid,
	input vga_pkg::bus_data_t axi_rdata
);

	import vga_pkg::*;

	localparam int TOTAL_PIXELS = H_VISIBLE * V_VISIBLE;
	localparam int BEAT_WIDTH = BURST_LENGTH > 1 ? $clog2(BURST_LENGTH) : 1;

	// Pixel index at which the last burst of a frame starts
	localparam pixel_count_t LAST_BURST_START = pixel_count_t'(TOTAL_PIXELS - BURST_LENGTH);
	localparam pixel_count_t BURST_PIXELS = pixel_count_t'(BURST_LENGTH);

	// Four bytes per RGBA word
	localparam bus_addr_t BURST_BYTES = bus_addr_t'(BURST_LENGTH * 4);
	localparam logic [BEAT_WIDTH-1:0] LAST_BEAT = BEAT_WIDTH'(BURST_LENGTH - 1);

	// Burst may only start with this much free space left
	localparam int FIFO_ROOM_LEVEL = FIFO_DEPTH - BURST_LENGTH - 1;

	raster_status_t raster;
	fetch_state_t fetch_state;
	bus_addr_t fetch_addr;
	pixel_count_t pixel_count;
	logic [BEAT_WIDTH-1:0] beat_count;
	bus_data_t fifo_head;
	logic fifo_empty;
	logic fifo_almost_empty;
	logic fifo_pop;

	vga_timing_generator
	#(
		.H_VISIBLE(H_VISIBLE),
		.H_FRONT(H_FRONT),
		.H_SYNC(H_SYNC),
		.H_BACK(H_BACK),
		.V_VISIBLE(V_VISIBLE),
		.V_FRONT(V_FRONT),
		.V_SYNC(V_SYNC),
		.V_BACK(V_BACK)
	) timing_generator
	(
		.clk(clk),
		.reset(reset),
		.status(raster),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs)
	);

	// One pixel leaves per visible pixel slot
	assign fifo_pop = raster.pixel_enable && raster.in_visible_region && !fifo_empty;

	// Every returned word goes straight in, room was checked before the address
	// Frame start flush lets the stream realign after an underrun
	sync_fifo
	#(
		.DATA_WIDTH($bits(bus_data_t)),
		.NUM_ENTRIES(FIFO_DEPTH),
		.ALMOST_EMPTY_THRESHOLD(FIFO_ROOM_LEVEL)
	) pixel_fifo
	(
		.clk(clk),
		.reset(reset),
		.flush(raster.new_frame),
		.enqueue(axi_rvalid),
		.dequeue(fifo_pop),
		.value_in(axi_rdata),
		.value_out(fifo_head),
		.empty(fifo_empty),
		.full(),
		.almost_empty(fifo_almost_empty)
	);

	// Burst fetch sequencer
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			fetch_state <= wait_frame_start;
			fetch_addr <= FB_BASE_ADDR;
			pixel_count <= '0;
			beat_count <= '0;
		end
		else
		begin
			case (fetch_state)
				wait_frame_start:
				begin
					// FIFO is flushed on the same pulse, so no room check
					if (raster.new_frame)
					begin
						fetch_state <= issue_addr;
						fetch_addr <= FB_BASE_ADDR;
						pixel_count <= '0;
					end
				end

				wait_fifo_room:
				begin
					if (fifo_almost_empty)
						fetch_state <= issue_addr;
				end

				issue_addr:
				begin
					// Address and valid hold until the slave takes them
					if (axi_arready)
					begin
						fetch_state <= burst_active;
						beat_count <= '0;
					end
				end

				burst_active:
				begin
					// Gaps between words just stall the beat count
					if (axi_rvalid)
					begin
						if (beat_count == LAST_BEAT)
						begin
							beat_count <= '0;
							if (pixel_count == LAST_BURST_START)
								fetch_state <= wait_frame_start;
							else
							begin
								// Go again at once if the FIFO already has room
								if (fifo_almost_empty)
									fetch_state <= issue_addr;
								else
									fetch_state <= wait_fifo_room;

								fetch_addr <= fetch_addr + BURST_BYTES;
								pixel_count <= pixel_count + BURST_PIXELS;
							end
						end
						else
							beat_count <= beat_count + 1'b1;
					end
				end

				default:
					fetch_state <= wait_frame_start;
			endcase
		end
	end

	assign axi_arvalid = fetch_state == issue_addr;
	assign axi_araddr = fetch_addr;

	// Pixel enable doubles as the DAC clock
	assign vga_clk = raster.pixel_enable;
	assign vga_blank_n = raster.in_visible_region;

	// Upper three bytes are colour, alpha is dropped
	assign vga_r = fifo_head[31:24];
	assign vga_g = fifo_head[23:16];
	assign vga_b = fifo_head[15:8];

endmodule

/* verification/tb_clock_gen.sv */
// ##########################################################
// Testbench clock and reset source, 20 ns period
// ##########################################################

module tb_clock_gen
(
	output logic clk,
	output logic reset
);

	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = !clk;
	end

	// Reset held for the first 10 rising edges
	initial
	begin
		reset = 1'b1;
		repeat (10)
			@(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* verification/axi_mem_model.sv */
// ##########################################################
// Testbench memory slave for read bursts. Data is derived from
// the word address, optional random stalls on address and data
// ##########################################################

module axi_mem_model
#(
	parameter int BURST_WORDS = 8
)
(
	input clk,
	input reset,
	input stall_mode,
	input vga_pkg::bus_addr_t araddr,
	input arvalid,
	output logic arready,
	output logic rvalid,
	output vga_pkg::bus_data_t rdata
);

	timeunit 1ns;
	timeprecision 100ps;

	import vga_pkg::*;

	integer seed = 32'h969bae94;
	int ready_delay;
	int ready_wait;
	int gap;
	int beat;
	logic busy;
	bus_addr_t burst_addr;
	bus_addr_t word_addr;

	// Stall length in clocks, zero unless stalls are on
	function automatic int draw_delay(input int limit);
		int r;
		if (!stall_mode)
			return 0;
		r = $random(seed);
		return (r & 32'h7fffffff) % (limit + 1);
	endfunction

	initial
	begin
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		busy = 1'b0;
		ready_delay = 0;
		ready_wait = 0;
		gap = 0;
		beat = 0;
	end

	assign word_addr = burst_addr + bus_addr_t'(4 * beat);

	always @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rdata <= '0;
			busy <= 1'b0;
			ready_wait <= 0;
			beat <= 0;
			gap <= 0;
		end
		else
		begin
			// Address phase, ready comes after a drawn delay
			if (arvalid && arready)
			begin
				arready <= 1'b0;
				burst_addr <= araddr;
				busy <= 1'b1;
				beat <= 0;
				gap <= draw_delay(1);
				ready_wait <= 0;
				ready_delay <= draw_delay(2);
			end
			else if (arvalid && !busy)
			begin
				if (ready_wait >= ready_delay)
					arready <= 1'b1;
				else
					ready_wait <= ready_wait + 1;
			end

			// Data phase, gaps of at most one clock keep up with the pixel rate
			rvalid <= 1'b0;
			if (busy)
			begin
				if (gap > 0)
					gap <= gap - 1;
				else
				begin
					rvalid <= 1'b1;
					// Low byte stands in for alpha
					rdata <= {word_addr[31:8], 8'hAA};
					if (beat == BURST_WORDS - 1)
						busy <= 1'b0;
					else
						beat <= beat + 1;
					gap <= draw_delay(1);
				end
			end
		end
	end

endmodule

/* verification/vga_controller_tb.sv */
// ##########################################################
// Directed tests for the display controller on a small raster
// with a burst memory model, run as the simulation top
// ##########################################################

module vga_controller_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import vga_pkg::*;

	localparam bus_addr_t BASE = 32'h10000000;
	localparam int LINE_PIXELS = 40;
	localparam int FRAME_LINES = 7;
	localparam int VISIBLE_PIXELS = 128;
	localparam int BURSTS = 16;
	localparam int TIMEOUT = 2000;

	logic clk;
	logic reset;
	logic stall_mode;
	color_t vga_r;
	color_t vga_g;
	color_t vga_b;
	logic vga_clk;
	logic vga_blank_n;
	logic vga_hs;
	logic vga_vs;
	bus_addr_t axi_araddr;
	logic axi_arvalid;
	logic axi_arready;
	logic axi_rvalid;
	bus_data_t axi_rdata;

	// Channel monitor state
	logic prev_wait;
	bus_addr_t prev_addr;
	int words_in_burst;

	tb_clock_gen clock_gen
	(
		.clk(clk),
		.reset(reset)
	);

	axi_mem_model #(.BURST_WORDS(8)) mem_model
	(
		.clk(clk),
		.reset(reset),
		.stall_mode(stall_mode),
		.araddr(axi_araddr),
		.arvalid(axi_arvalid),
		.arready(axi_arready),
		.rvalid(axi_rvalid),
		.rdata(axi_rdata)
	);

	vga_controller
	#(
		.H_VISIBLE(32),
		.H_FRONT(2),
		.H_SYNC(4),
		.H_BACK(2),
		.V_VISIBLE(4),
		.V_FRONT(1),
		.V_SYNC(1),
		.V_BACK(1),
		.BURST_LENGTH(8),
		.FIFO_DEPTH(16),
		.FB_BASE_ADDR(BASE)
	) u_dut
	(
		.clk(clk),
		.reset(reset),
		.vga_r(vga_r),
		.vga_g(vga_g),
		.vga_b(vga_b),
		.vga_clk(vga_clk),
		.vga_blank_n(vga_blank_n),
		.vga_hs(vga_hs),
		.vga_vs(vga_vs),
		.axi_araddr(axi_araddr),
		.axi_arvalid(axi_arvalid),
		.axi_arready(axi_arready),
		.axi_rvalid(axi_rvalid),
		.axi_rdata(axi_rdata)
	);

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	// No burst is open before the first address
	initial
	begin
		prev_wait = 1'b0;
		prev_addr = '0;
		words_in_burst = 8;
	end

	// Address and valid hold while waiting for ready
	// Next address only once all words of a burst are in
	always @(negedge clk)
	begin
		if (!reset)
		begin
			if (prev_wait)
			begin
				assert (axi_arvalid)
				else fail_run($sformatf("[ERROR] axi_arvalid: expected %h, got %h",
					1'b1, axi_arvalid));
				assert (axi_araddr == prev_addr)
				else fail_run($sformatf("[ERROR] axi_araddr: expected %h, got %h",
					prev_addr, axi_araddr));
			end
			if (axi_arvalid)
				assert (words_in_burst == 8)
				else fail_run($sformatf("[ERROR] axi_arvalid: raised after %h words of a burst",
					words_in_burst));
			prev_wait = axi_arvalid && !axi_arready;
			prev_addr = axi_araddr;
			if (axi_arvalid && axi_arready)
				words_in_burst = 0;
			if (axi_rvalid)
				words_in_burst++;
			assert (words_in_burst <= 8)
			else fail_run($sformatf("[ERROR] axi_rvalid: burst word count %h exceeds 8",
				words_in_burst));
		end
	end

	// Idle levels during reset and on the first clock after it
	task automatic verify_reset_levels();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (reset)
		begin
			assert (!axi_arvalid && vga_hs && vga_vs && !vga_blank_n && !vga_clk)
			else fail_run($sformatf(
				"[ERROR] reset levels: arvalid %h hs %h vs %h blank_n %h clk %h",
				axi_arvalid, vga_hs, vga_vs, vga_blank_n, vga_clk));
			cycles++;
			if (cycles > 50)
				fail_run("Reset was never released");
			@(negedge clk);
		end
		assert (!axi_arvalid && vga_hs && vga_vs && !vga_blank_n && !vga_clk)
		else fail_run($sformatf(
			"[ERROR] after reset: arvalid %h hs %h vs %h blank_n %h clk %h",
			axi_arvalid, vga_hs, vga_vs, vga_blank_n, vga_clk));
	endtask

	// Fetch order and pixel contents over one frame
	task automatic trace_frame_fetch();
		int cycles;
		int k;
		int n;
		bus_addr_t pixel_addr;
		cycles = 0;
		// Frame fetch opens with the base address
		while (!(axi_arvalid && axi_arready))
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				fail_run("No read address was accepted at frame start");
		end
		assert (axi_araddr == BASE)
		else fail_run($sformatf("[ERROR] axi_araddr: expected %h, got %h", BASE, axi_araddr));
		k = 1;
		n = 0;
		cycles = 0;
		while (n < VISIBLE_PIXELS)
		begin
			@(negedge clk);
			if (axi_arvalid && axi_arready)
			begin
				assert (k < BURSTS && axi_araddr == BASE + bus_addr_t'(32 * k))
				else fail_run($sformatf("[ERROR] axi_araddr: expected %h, got %h",
					BASE + bus_addr_t'(32 * k), axi_araddr));
				k++;
			end
			if (vga_clk && vga_blank_n)
			begin
				pixel_addr = BASE + bus_addr_t'(4 * n);
				assert ({vga_r, vga_g, vga_b} == pixel_addr[31:8])
				else fail_run($sformatf("[ERROR] vga_rgb: expected %h, got %h",
					pixel_addr[31:8], {vga_r, vga_g, vga_b}));
				n++;
			end
			cycles++;
			if (cycles > TIMEOUT)
				fail_run("Visible pixels of a frame did not all appear");
		end
		assert (k == BURSTS)
		else fail_run($sformatf("[ERROR] burst count: expected %h, got %h", BURSTS, k));
	endtask

	// Line length, sync widths and visible area over one frame
	task automatic measure_raster();
		int cycles;
		int line;
		int pos;
		int hs_low;
		int vs_low;
		int shown;
		int vs_lines;
		// Align on the end of vertical sync, then the first visible pixel
		cycles = 0;
		while (vga_vs)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				fail_run("Vertical sync was not found");
		end
		cycles = 0;
		while (!vga_vs)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				fail_run("Vertical sync did not end");
		end
		cycles = 0;
		while (!(vga_clk && vga_blank_n))
		begin
			@(negedge clk);
			cycles++;
			if (cycles > TIMEOUT)
				fail_run("First visible pixel was not found");
		end
		vs_lines = 0;
		for (line = 0; line < FRAME_LINES; line++)
		begin
			hs_low = 0;
			vs_low = 0;
			shown = 0;
			for (pos = 0; pos < LINE_PIXELS; pos++)
			begin
				cycles = 0;
				while (!vga_clk)
				begin
					@(negedge clk);
					cycles++;
					if (cycles > 10)
						fail_run("Pixel clock stopped");
				end
				if (pos == 0 && line < 4)
					assert (vga_blank_n)
					else fail_run($sformatf("[ERROR] vga_blank_n: line %h starts at %h",
						line, vga_blank_n));
				hs_low += !vga_hs;
				vs_low += !vga_vs;
				shown += vga_blank_n;
				@(negedge clk);
			end
			assert (hs_low == 4)
			else fail_run($sformatf("[ERROR] vga_hs: expected %h low, got %h", 4, hs_low));
			assert (shown == (line < 4 ? 32 : 0))
			else fail_run($sformatf("[ERROR] vga_blank_n: line %h shows %h pixels", line, shown));
			assert (vs_low == 0 || vs_low == LINE_PIXELS)
			else fail_run($sformatf("[ERROR] vga_vs: partial line, %h pixels low", vs_low));
			if (vs_low != 0)
				vs_lines++;
		end
		assert (vs_lines == 1)
		else fail_run($sformatf("[ERROR] vga_vs: expected %h line, got %h", 1, vs_lines));
	endtask

	initial
	begin
		stall_mode = 1'b0;
		verify_reset_levels();
		trace_frame_fetch();
		trace_frame_fetch();
		// Memory is idle here, last burst of the frame is already in
		@(posedge clk);
		stall_mode <= 1'b1;
		trace_frame_fetch();
		trace_frame_fetch();
		measure_raster();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

/* build.f */
common/vga_pkg.sv
verilog/sync_fifo.sv
vga/vga_timing_generator.sv
vga/vga_controller.sv
verification/tb_clock_gen.sv
verification/axi_mem_model.sv
verification/vga_controller_tb.sv
